/* hdl/bignum_pkg.sv */
package bignum_pkg;

    localparam int ADR_W     = 20;
    localparam int WRD_W     = 16;
    localparam int SIZE_W    = 16;
    localparam int VAR_N     = 16;
    localparam int VAR_IDX_W = 4;

    // Command opcodes, upper nibble of the command byte
    localparam logic [3:0] OP_ADD   = 4'd0;
    localparam logic [3:0] OP_SUB   = 4'd1;
    localparam logic [3:0] OP_LOAD  = 4'd4;
    localparam logic [3:0] OP_STORE = 4'd5;

    // RS-232 core register map
    localparam logic [4:0] RX_OFS     = 5'd0;
    localparam logic [4:0] TX_OFS     = 5'd4;
    localparam logic [4:0] STATUS_OFS = 5'd8;
    localparam int         TX_RDY_BIT = 6;
    localparam int         RX_RDY_BIT = 7;

    typedef struct packed {
        logic [ADR_W-1:0]  base;
        logic [SIZE_W-1:0] size;   // In words
    } var_entry_t;

    typedef struct packed {
        logic [ADR_W-1:0] addr;
        logic [WRD_W-1:0] wdata;
        logic             wen;
    } sram_req_t;

    typedef struct packed {
        logic             sub;
        var_entry_t       x1;
        var_entry_t       x2;
        logic [ADR_W-1:0] x3_base;
    } arith_cmd_t;

endpackage

/* hdl/uart_byte_port.sv */
`timescale 1ns/10ps

module uart_byte_port (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_rx_req,
    input  logic        i_tx_req,
    input  logic [7:0]  i_tx_byte,
    input  logic [31:0] i_avm_readdata,
    input  logic        i_avm_waitrequest,
    output logic [4:0]  o_avm_address,
    output logic        o_avm_read,
    output logic        o_avm_write,
    output logic [31:0] o_avm_writedata,
    output logic [7:0]  o_rx_byte,
    output logic        o_done
);

    typedef enum logic [1:0] {S_IDLE, S_POLL, S_XFER} state_t;

    state_t     state;
    logic       is_tx;
    logic [7:0] tx_byte;
    logic       rdy;

    assign rdy = i_avm_readdata[is_tx ? bignum_pkg::TX_RDY_BIT : bignum_pkg::RX_RDY_BIT];

    assign o_avm_writedata = {24'd0, tx_byte};
    assign o_rx_byte       = i_avm_readdata[7:0];
    assign o_done          = (state == S_XFER) && !i_avm_waitrequest;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= S_IDLE;
            is_tx         <= 1'b0;
            o_avm_address <= bignum_pkg::STATUS_OFS;
            o_avm_read    <= 1'b0;
            o_avm_write   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (i_rx_req || i_tx_req) begin
                    is_tx         <= i_tx_req;
                    o_avm_address <= bignum_pkg::STATUS_OFS;
                    o_avm_read    <= 1'b1;
                    state         <= S_POLL;
                end
                // Status read repeats until the ready bit shows up
                S_POLL: if (!i_avm_waitrequest && rdy) begin
                    o_avm_address <= is_tx ? bignum_pkg::TX_OFS : bignum_pkg::RX_OFS;
                    o_avm_read    <= !is_tx;
                    o_avm_write   <= is_tx;
                    state         <= S_XFER;
                end
                S_XFER: if (!i_avm_waitrequest) begin
                    o_avm_address <= bignum_pkg::STATUS_OFS;
                    o_avm_read    <= 1'b0;
                    o_avm_write   <= 1'b0;
                    state         <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_tx_req) tx_byte <= i_tx_byte;
    end

endmodule

/* hdl/var_table.sv */
`timescale 1ns/10ps

module var_table (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_wr,
    input  logic [bignum_pkg::VAR_IDX_W-1:0] i_wr_idx,
    input  bignum_pkg::var_entry_t           i_wr_entry,
    input  logic                             i_adv,
    input  logic [bignum_pkg::ADR_W-1:0]     i_adv_addr,
    input  logic [bignum_pkg::VAR_IDX_W-1:0] i_rd_idx_a,
    input  logic [bignum_pkg::VAR_IDX_W-1:0] i_rd_idx_b,
    input  logic [bignum_pkg::VAR_IDX_W-1:0] i_rd_idx_c,
    output bignum_pkg::var_entry_t           o_entry_a,
    output bignum_pkg::var_entry_t           o_entry_b,
    output bignum_pkg::var_entry_t           o_entry_c,
    output logic [bignum_pkg::ADR_W-1:0]     o_next_free
);

    bignum_pkg::var_entry_t tbl [bignum_pkg::VAR_N];

    assign o_entry_a = tbl[i_rd_idx_a];
    assign o_entry_b = tbl[i_rd_idx_b];
    assign o_entry_c = tbl[i_rd_idx_c];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < bignum_pkg::VAR_N; i++) begin
                tbl[i] <= '0;
            end
            o_next_free <= '0;
        end else begin
            if (i_wr) tbl[i_wr_idx] <= i_wr_entry;
            if (i_adv) o_next_free <= i_adv_addr;   // Bump allocator, never freed
        end
    end

endmodule

/* hdl/cmd_sequencer.sv */
`timescale 1ns/10ps

module cmd_sequencer (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic [7:0]                       i_rx_byte,
    input  logic                             i_byte_done,
    input  bignum_pkg::var_entry_t           i_entry_a,
    input  bignum_pkg::var_entry_t           i_entry_b,
    input  bignum_pkg::var_entry_t           i_entry_c,
    input  logic [bignum_pkg::ADR_W-1:0]     i_next_free,
    input  logic [bignum_pkg::WRD_W-1:0]     i_sram_rdata,
    input  logic                             i_arith_done,
    input  logic [bignum_pkg::SIZE_W-1:0]    i_arith_size,
    output logic                             o_rx_req,
    output logic                             o_tx_req,
    output logic [7:0]                       o_tx_byte,
    output logic                             o_tbl_wr,
    output logic [bignum_pkg::VAR_IDX_W-1:0] o_tbl_wr_idx,
    output bignum_pkg::var_entry_t           o_tbl_wr_entry,
    output logic                             o_tbl_adv,
    output logic [bignum_pkg::ADR_W-1:0]     o_tbl_adv_addr,
    output logic [bignum_pkg::VAR_IDX_W-1:0] o_rd_idx_a,
    output logic [bignum_pkg::VAR_IDX_W-1:0] o_rd_idx_b,
    output logic [bignum_pkg::VAR_IDX_W-1:0] o_rd_idx_c,
    output bignum_pkg::sram_req_t            o_sram,
    output logic                             o_start,
    output bignum_pkg::arith_cmd_t           o_cmd,
    output logic                             o_arith_busy
);

    typedef enum logic [2:0] {
        S_BOOT, S_CMD, S_OPND, S_ARITH, S_SIZE_RX, S_DATA_RX, S_SIZE_TX, S_DATA_TX
    } state_t;

    state_t                             state;
    logic                               sub_r;
    logic [bignum_pkg::VAR_IDX_W-1:0]   x1_r, x2_r, x3_r;
    logic                               bsel;     // High byte of the current word
    logic [bignum_pkg::SIZE_W-1:0]      cnt_r;    // Words left
    logic [bignum_pkg::ADR_W-1:0]       addr_r;
    logic                               wen_r;
    logic [bignum_pkg::WRD_W-1:0]       wdata_r;
    logic [7:0]                         lo_r;
    logic                               start_r;
    logic [bignum_pkg::SIZE_W-1:0]      new_size;
    logic [bignum_pkg::SIZE_W-1:0]      tx_word;

    assign o_arith_busy = (state == S_ARITH);
    assign o_start      = start_r;
    assign o_cmd        = '{sub: sub_r, x1: i_entry_a, x2: i_entry_b, x3_base: i_next_free};
    assign o_sram       = '{addr: addr_r, wdata: wdata_r, wen: wen_r};

    assign o_rd_idx_a = x1_r;
    assign o_rd_idx_b = x2_r;
    assign o_rd_idx_c = x3_r;

    // New variables always land at next_free
    assign new_size       = o_arith_busy ? i_arith_size : {i_rx_byte, lo_r};
    assign o_tbl_wr       = (o_arith_busy && i_arith_done) ||
                            (state == S_SIZE_RX && i_byte_done && bsel);
    assign o_tbl_adv      = o_tbl_wr;
    assign o_tbl_wr_idx   = x3_r;
    assign o_tbl_wr_entry = '{base: i_next_free, size: new_size};
    assign o_tbl_adv_addr = i_next_free + bignum_pkg::ADR_W'(new_size);

    assign tx_word   = (state == S_SIZE_TX) ? i_entry_c.size : i_sram_rdata;
    assign o_tx_byte = bsel ? tx_word[15:8] : tx_word[7:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_BOOT;
            sub_r    <= 1'b0;
            x1_r     <= '0;
            x2_r     <= '0;
            x3_r     <= '0;
            bsel     <= 1'b0;
            cnt_r    <= '0;
            addr_r   <= '0;
            wen_r    <= 1'b0;
            start_r  <= 1'b0;
            o_rx_req <= 1'b0;
            o_tx_req <= 1'b0;
        end else begin
            o_rx_req <= 1'b0;
            o_tx_req <= 1'b0;
            start_r  <= 1'b0;
            wen_r    <= 1'b0;
            if (wen_r) addr_r <= addr_r + 1'b1;   // Step after each STORE write
            case (state)
                S_BOOT: begin
                    o_rx_req <= 1'b1;
                    state    <= S_CMD;
                end
                S_CMD: if (i_byte_done) begin
                    sub_r <= (i_rx_byte[7:4] == bignum_pkg::OP_SUB);
                    x3_r  <= i_rx_byte[3:0];
                    case (i_rx_byte[7:4])
                        bignum_pkg::OP_ADD, bignum_pkg::OP_SUB: begin
                            o_rx_req <= 1'b1;
                            state    <= S_OPND;
                        end
                        bignum_pkg::OP_LOAD: begin
                            o_tx_req <= 1'b1;
                            state    <= S_SIZE_TX;
                        end
                        bignum_pkg::OP_STORE: begin
                            o_rx_req <= 1'b1;
                            state    <= S_SIZE_RX;
                        end
                        default: o_rx_req <= 1'b1;   // Unknown opcode dropped
                    endcase
                end
                S_OPND: if (i_byte_done) begin
                    x1_r    <= i_rx_byte[7:4];
                    x2_r    <= i_rx_byte[3:0];
                    start_r <= 1'b1;
                    state   <= S_ARITH;
                end
                S_ARITH: if (i_arith_done) begin
                    o_rx_req <= 1'b1;
                    state    <= S_CMD;
                end
                S_SIZE_RX: if (i_byte_done) begin
                    bsel     <= !bsel;
                    o_rx_req <= 1'b1;
                    if (bsel) begin
                        addr_r <= i_next_free;
                        cnt_r  <= {i_rx_byte, lo_r};
                        state  <= ({i_rx_byte, lo_r} == '0) ? S_CMD : S_DATA_RX;
                    end
                end
                S_DATA_RX: if (i_byte_done) begin
                    bsel     <= !bsel;
                    o_rx_req <= 1'b1;
                    if (bsel) begin
                        wen_r <= 1'b1;
                        cnt_r <= cnt_r - 1'b1;
                        if (cnt_r == 1) state <= S_CMD;
                    end
                end
                S_SIZE_TX: if (i_byte_done) begin
                    bsel <= !bsel;
                    if (!bsel) begin
                        o_tx_req <= 1'b1;
                    end else begin
                        addr_r <= i_entry_c.base;
                        cnt_r  <= i_entry_c.size;
                        if (i_entry_c.size == '0) begin
                            o_rx_req <= 1'b1;
                            state    <= S_CMD;
                        end else begin
                            o_tx_req <= 1'b1;
                            state    <= S_DATA_TX;
                        end
                    end
                end
                S_DATA_TX: if (i_byte_done) begin
                    bsel <= !bsel;
                    if (!bsel) begin
                        o_tx_req <= 1'b1;
                    end else begin
                        addr_r <= addr_r + 1'b1;
                        cnt_r  <= cnt_r - 1'b1;
                        if (cnt_r == 1) begin
                            o_rx_req <= 1'b1;
                            state    <= S_CMD;
                        end else begin
                            o_tx_req <= 1'b1;
                        end
                    end
                end
                default: state <= S_BOOT;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == S_SIZE_RX || state == S_DATA_RX) && i_byte_done && !bsel) begin
            lo_r <= i_rx_byte;
        end
        if (state == S_DATA_RX && i_byte_done && bsel) wdata_r <= {i_rx_byte, lo_r};
    end

endmodule

/* hdl/addsub_unit.sv */
`timescale 1ns/10ps

module addsub_unit (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  bignum_pkg::arith_cmd_t        i_cmd,
    input  logic [bignum_pkg::WRD_W-1:0]  i_sram_rdata,
    output bignum_pkg::sram_req_t         o_sram,
    output logic                          o_done,
    output logic [bignum_pkg::SIZE_W-1:0] o_size
);

    typedef enum logic [2:0] {S_IDLE, S_RD1, S_RD2, S_WR, S_CARRY, S_DONE} state_t;

    state_t                         state;
    logic                           sub_r;
    logic                           carry_r;
    logic [bignum_pkg::ADR_W-1:0]   p1, p2, p3;
    logic [bignum_pkg::SIZE_W-1:0]  size1, size2;
    logic [bignum_pkg::SIZE_W-1:0]  idx;
    logic [bignum_pkg::SIZE_W-1:0]  size_r;
    logic [bignum_pkg::SIZE_W-1:0]  max_size;
    logic [bignum_pkg::WRD_W-1:0]   a_r, acc_r, b_word;
    logic [bignum_pkg::WRD_W:0]     sum;

    assign max_size = (i_cmd.x1.size > i_cmd.x2.size) ? i_cmd.x1.size : i_cmd.x2.size;

    // Past the end of the shorter operand its words read as zero
    assign b_word = (idx < size2) ? i_sram_rdata : '0;
    assign sum    = {1'b0, a_r} + {1'b0, b_word ^ {bignum_pkg::WRD_W{sub_r}}} +
                    {{bignum_pkg::WRD_W{1'b0}}, carry_r};

    always_comb begin
        o_sram.wdata = acc_r;
        o_sram.wen   = (state == S_WR) || (state == S_CARRY);
        case (state)
            S_RD1:   o_sram.addr = p1;
            S_RD2:   o_sram.addr = p2;
            default: o_sram.addr = p3;
        endcase
    end

    assign o_done = (state == S_DONE);
    assign o_size = size_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= S_IDLE;
            sub_r   <= 1'b0;
            carry_r <= 1'b0;
            p1      <= '0;
            p2      <= '0;
            p3      <= '0;
            size1   <= '0;
            size2   <= '0;
            idx     <= '0;
            size_r  <= '0;
        end else begin
            case (state)
                S_IDLE: if (i_start) begin
                    sub_r   <= i_cmd.sub;
                    carry_r <= i_cmd.sub;   // Two's complement +1
                    p1      <= i_cmd.x1.base;
                    p2      <= i_cmd.x2.base;
                    p3      <= i_cmd.x3_base;
                    size1   <= i_cmd.x1.size;
                    size2   <= i_cmd.x2.size;
                    idx     <= '0;
                    size_r  <= max_size;
                    state   <= (max_size == '0) ? S_DONE : S_RD1;
                end
                S_RD1: state <= S_RD2;
                S_RD2: begin
                    carry_r <= sum[bignum_pkg::WRD_W];
                    state   <= S_WR;
                end
                S_WR: begin
                    p1  <= p1 + 1'b1;
                    p2  <= p2 + 1'b1;
                    p3  <= p3 + 1'b1;
                    idx <= idx + 1'b1;
                    if (idx + 1'b1 != size_r) begin
                        state <= S_RD1;
                    end else if (!sub_r && carry_r) begin
                        size_r <= size_r + 1'b1;   // Grow by one word
                        state  <= S_CARRY;
                    end else begin
                        state <= S_DONE;
                    end
                end
                S_CARRY: state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_RD1) a_r <= (idx < size1) ? i_sram_rdata : '0;
        if (state == S_RD2) begin
            acc_r <= sum[bignum_pkg::WRD_W-1:0];
        end else if (state == S_WR) begin
            acc_r <= {{(bignum_pkg::WRD_W-1){1'b0}}, 1'b1};   // Carry word
        end
    end

endmodule

/* hdl/bignum_calc.sv */
`timescale 1ns/10ps

module bignum_calc (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    output logic [4:0]                   o_avm_address,
    output logic                         o_avm_read,
    input  logic [31:0]                  i_avm_readdata,
    output logic                         o_avm_write,
    output logic [31:0]                  o_avm_writedata,
    input  logic                         i_avm_waitrequest,
    output logic [bignum_pkg::ADR_W-1:0] o_sram_addr,
    inout  wire  [bignum_pkg::WRD_W-1:0] io_sram_dq,
    output logic                         o_sram_we_n,
    output logic                         o_sram_ce_n,
    output logic                         o_sram_oe_n,
    output logic                         o_sram_lb_n,
    output logic                         o_sram_ub_n
);

    logic                             rx_req, tx_req, byte_done;
    logic [7:0]                       tx_byte, rx_byte;
    logic                             tbl_wr, tbl_adv;
    logic [bignum_pkg::VAR_IDX_W-1:0] tbl_wr_idx, idx_a, idx_b, idx_c;
    bignum_pkg::var_entry_t           tbl_wr_entry, entry_a, entry_b, entry_c;
    logic [bignum_pkg::ADR_W-1:0]     tbl_adv_addr, next_free;
    logic [bignum_pkg::WRD_W-1:0]     sram_rdata;
    bignum_pkg::sram_req_t            seq_sram, arith_sram, sram;
    bignum_pkg::arith_cmd_t           arith_cmd;
    logic                             arith_start, arith_done, arith_busy;
    logic [bignum_pkg::SIZE_W-1:0]    arith_size;

    assign sram        = arith_busy ? arith_sram : seq_sram;
    assign o_sram_addr = sram.addr;
    assign io_sram_dq  = sram.wen ? sram.wdata : 'z;
    assign sram_rdata  = io_sram_dq;
    assign o_sram_we_n = !sram.wen;
    assign o_sram_ce_n = 1'b0;
    assign o_sram_oe_n = 1'b0;
    assign o_sram_lb_n = 1'b0;
    assign o_sram_ub_n = 1'b0;

    uart_byte_port uart_byte_port_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_rx_req          (rx_req),
        .i_tx_req          (tx_req),
        .i_tx_byte         (tx_byte),
        .i_avm_readdata    (i_avm_readdata),
        .i_avm_waitrequest (i_avm_waitrequest),
        .o_avm_address     (o_avm_address),
        .o_avm_read        (o_avm_read),
        .o_avm_write       (o_avm_write),
        .o_avm_writedata   (o_avm_writedata),
        .o_rx_byte         (rx_byte),
        .o_done            (byte_done)
    );

    var_table var_table_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr        (tbl_wr),
        .i_wr_idx    (tbl_wr_idx),
        .i_wr_entry  (tbl_wr_entry),
        .i_adv       (tbl_adv),
        .i_adv_addr  (tbl_adv_addr),
        .i_rd_idx_a  (idx_a),
        .i_rd_idx_b  (idx_b),
        .i_rd_idx_c  (idx_c),
        .o_entry_a   (entry_a),
        .o_entry_b   (entry_b),
        .o_entry_c   (entry_c),
        .o_next_free (next_free)
    );

    cmd_sequencer cmd_sequencer_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rx_byte      (rx_byte),
        .i_byte_done    (byte_done),
        .i_entry_a      (entry_a),
        .i_entry_b      (entry_b),
        .i_entry_c      (entry_c),
        .i_next_free    (next_free),
        .i_sram_rdata   (sram_rdata),
        .i_arith_done   (arith_done),
        .i_arith_size   (arith_size),
        .o_rx_req       (rx_req),
        .o_tx_req       (tx_req),
        .o_tx_byte      (tx_byte),
        .o_tbl_wr       (tbl_wr),
        .o_tbl_wr_idx   (tbl_wr_idx),
        .o_tbl_wr_entry (tbl_wr_entry),
        .o_tbl_adv      (tbl_adv),
        .o_tbl_adv_addr (tbl_adv_addr),
        .o_rd_idx_a     (idx_a),
        .o_rd_idx_b     (idx_b),
        .o_rd_idx_c     (idx_c),
        .o_sram         (seq_sram),
        .o_start        (arith_start),
        .o_cmd          (arith_cmd),
        .o_arith_busy   (arith_busy)
    );

    addsub_unit addsub_unit_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (arith_start),
        .i_cmd        (arith_cmd),
        .i_sram_rdata (sram_rdata),
        .o_sram       (arith_sram),
        .o_done       (arith_done),
        .o_size       (arith_size)
    );

endmodule

/* test/bignum_calc_assert.sv */
`timescale 1ns/10ps

module bignum_calc_assert (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic [4:0]  i_avm_address,
    input logic        i_avm_read,
    input logic        i_avm_write,
    input logic [31:0] i_avm_writedata,
    input logic        i_avm_waitrequest,
    input logic        i_done
);

    a_no_rd_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_avm_read && i_avm_write))
        else $error("Avalon read and write high in the same cycle");

    // Master holds the whole request until waitrequest drops
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_avm_read || i_avm_write) && i_avm_waitrequest |=>
            $stable(i_avm_address) && $stable(i_avm_read) &&
            $stable(i_avm_write) && $stable(i_avm_writedata))
        else $error("Avalon outputs changed while waitrequest was high");

    // Done only on the data register access, never on a status poll
    a_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |-> !i_avm_waitrequest &&
            ((i_avm_read && i_avm_address == bignum_pkg::RX_OFS) ||
             (i_avm_write && i_avm_address == bignum_pkg::TX_OFS)))
        else $error("Byte done without a completed Avalon data access");

endmodule

bind uart_byte_port bignum_calc_assert bignum_calc_assert_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_avm_address     (o_avm_address),
    .i_avm_read        (o_avm_read),
    .i_avm_write       (o_avm_write),
    .i_avm_writedata   (o_avm_writedata),
    .i_avm_waitrequest (i_avm_waitrequest),
    .i_done            (o_done)
);

/* test/tb_bignum_calc.sv */
`timescale 1ns/10ps

module tb_bignum_calc;

    localparam int PERIOD      = 100;
    localparam int N_BYTES     = 89;   // Bytes in and out over all tests
    localparam int WDOG_CYCLES = 400 * N_BYTES;

    logic                         clk   = 1'b0;
    logic                         rst_n = 1'b0;
    logic [4:0]                   avm_address;
    logic                         avm_read;
    logic [31:0]                  avm_readdata    = '0;
    logic                         avm_write;
    logic [31:0]                  avm_writedata;
    logic                         avm_waitrequest = 1'b0;
    logic [bignum_pkg::ADR_W-1:0] sram_addr;
    wire  [bignum_pkg::WRD_W-1:0] sram_dq;
    logic                         sram_we_n, sram_ce_n, sram_oe_n, sram_lb_n, sram_ub_n;

    integer      seed = 32'h93858541;
    logic        stall;
    logic [31:0] rd;
    logic [7:0]  rx_q[$];
    logic [7:0]  cap_q[$];   // Bytes written to TX by the DUT
    logic [15:0] sram_mem [0:(1<<bignum_pkg::ADR_W)-1];
    logic [15:0] model_val [16][8];
    int          model_size [16];

    bignum_calc bignum_calc_i (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .o_avm_address     (avm_address),
        .o_avm_read        (avm_read),
        .i_avm_readdata    (avm_readdata),
        .o_avm_write       (avm_write),
        .o_avm_writedata   (avm_writedata),
        .i_avm_waitrequest (avm_waitrequest),
        .o_sram_addr       (sram_addr),
        .io_sram_dq        (sram_dq),
        .o_sram_we_n       (sram_we_n),
        .o_sram_ce_n       (sram_ce_n),
        .o_sram_oe_n       (sram_oe_n),
        .o_sram_lb_n       (sram_lb_n),
        .o_sram_ub_n       (sram_ub_n)
    );

    always #(PERIOD/2) clk = ~clk;

    // Asynchronous SRAM where read data follows the address
    assign sram_dq = (!sram_ce_n && !sram_oe_n && sram_we_n) ? sram_mem[sram_addr] : 'z;

    always @(negedge clk) begin
        if (!sram_ce_n && !sram_we_n) begin
            if (!sram_lb_n) sram_mem[sram_addr][7:0]  <= sram_dq[7:0];
            if (!sram_ub_n) sram_mem[sram_addr][15:8] <= sram_dq[15:8];
        end
    end

    // RS-232 core registers with random stalls and dropped ready bits
    always @(negedge clk) begin
        stall = (avm_read || avm_write) && (($random(seed) & 3) == 0);
        rd    = '0;
        if (avm_read && avm_address == bignum_pkg::STATUS_OFS) begin
            rd[bignum_pkg::RX_RDY_BIT] = (rx_q.size() != 0) && (($random(seed) & 3) != 0);
            rd[bignum_pkg::TX_RDY_BIT] = ($random(seed) & 3) != 0;
        end
        if (avm_read && avm_address == bignum_pkg::RX_OFS && !stall) begin
            rd[7:0] = rx_q.pop_front();
        end
        if (avm_write && avm_address == bignum_pkg::TX_OFS && !stall) begin
            assert (avm_writedata[31:8] == 24'd0) else begin
                $display("error tx_writedata: expected upper bits %06h, actual %06h",
                         24'd0, avm_writedata[31:8]);
                $display("Simulation FAILED");
                $fatal(1);
            end
            cap_q.push_back(avm_writedata[7:0]);
        end
        avm_waitrequest <= stall;
        avm_readdata    <= rd;
    end

    task automatic send_byte(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    task automatic store_var(input int idx, input int n, input logic [15:0] w0, w1, w2);
        logic [15:0] w [3];
        w = '{w0, w1, w2};
        send_byte({bignum_pkg::OP_STORE, 4'(idx)});
        send_byte(8'(n));
        send_byte(8'(n >> 8));
        for (int i = 0; i < n; i++) begin
            send_byte(w[i][7:0]);
            send_byte(w[i][15:8]);
            model_val[idx][i] = w[i];
        end
        model_size[idx] = n;
    endtask

    // Word-serial reference model where missing words of the shorter operand count as zero
    task automatic run_arith(input logic sub, input int x3, input int x1, input int x2);
        logic [15:0] res [8];
        logic [16:0] t;
        logic        c;
        logic [15:0] a, b;
        int          n;
        n = (model_size[x1] > model_size[x2]) ? model_size[x1] : model_size[x2];
        c = 1'b0;
        for (int i = 0; i < n; i++) begin
            a = (i < model_size[x1]) ? model_val[x1][i] : 16'h0;
            b = (i < model_size[x2]) ? model_val[x2][i] : 16'h0;
            t = sub ? {1'b0, a} - {1'b0, b} - 17'(c) : {1'b0, a} + {1'b0, b} + 17'(c);
            res[i] = t[15:0];
            c      = t[16];   // Borrow out for SUB
        end
        if (!sub && c) begin
            res[n] = 16'h1;
            n++;
        end
        for (int i = 0; i < n; i++) begin
            model_val[x3][i] = res[i];
        end
        model_size[x3] = n;
        send_byte({sub ? bignum_pkg::OP_SUB : bignum_pkg::OP_ADD, 4'(x3)});
        send_byte({4'(x1), 4'(x2)});
    endtask

    task automatic load_check(input int idx, input string name);
        logic [7:0] exp_q[$];
        logic [7:0] got;
        exp_q.push_back(8'(model_size[idx]));
        exp_q.push_back(8'(model_size[idx] >> 8));
        for (int i = 0; i < model_size[idx]; i++) begin
            exp_q.push_back(model_val[idx][i][7:0]);
            exp_q.push_back(model_val[idx][i][15:8]);
        end
        send_byte({bignum_pkg::OP_LOAD, 4'(idx)});
        while (cap_q.size() < exp_q.size()) @(negedge clk);
        foreach (exp_q[i]) begin
            got = cap_q.pop_front();
            assert (got == exp_q[i]) else begin
                $display("error %s byte %0d: expected %02h, actual %02h",
                         name, i, exp_q[i], got);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
    endtask

    initial begin
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        store_var(0, 3, 16'h1234, 16'hABCD, 16'h0F0F);
        load_check(0, "store_load");

        store_var(1, 2, 16'hFFFF, 16'h8000, 16'h0000);
        store_var(2, 2, 16'h0001, 16'h8000, 16'h0000);
        run_arith(1'b0, 3, 1, 2);   // Carry out of the top word
        load_check(3, "add_carry");

        store_var(4, 3, 16'h0000, 16'h0000, 16'h0005);
        store_var(5, 1, 16'h0001, 16'h0000, 16'h0000);
        run_arith(1'b1, 6, 4, 5);
        load_check(6, "sub_borrow");

        run_arith(1'b0, 1, 1, 0);
        load_check(1, "add_in_place");

        send_byte(8'h27);   // Opcode 2
        load_check(6, "ignored_opcode");

        if (cap_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("DUT sent %0d bytes that no LOAD asked for", cap_q.size());
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    initial begin
        #(PERIOD * WDOG_CYCLES);
        $display("Timeout after %0d cycles, DUT stopped moving bytes", WDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

/* bignum_calc.f */
hdl/bignum_pkg.sv
hdl/uart_byte_port.sv
hdl/var_table.sv
hdl/cmd_sequencer.sv
hdl/addsub_unit.sv
hdl/bignum_calc.sv
test/bignum_calc_assert.sv
test/tb_bignum_calc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build tb_bignum_calc with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_bignum_calc \
    -Mdir obj_dir -o sim_bignum_calc -f bignum_calc.f > build.log 2>&1 &&
./obj_dir/sim_bignum_calc > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "Test passed" ||
    { echo "Test failed, see build.log and sim.log"; exit 1; }
